// ==== common/hist_pkg.sv ====
// shared widths, typedefs and constants of the histogram to AXI write path
// every RTL block of the transfer imports what it needs from here
package hist_pkg;

    localparam int NUM_FRAME_BITS_DEF = 4;      // default frame number width

    typedef logic [31:0] hist_word_t;           // one histogram data word
    typedef logic [31:0] axi_addr_t;            // system memory byte address
    typedef logic [1:0]  page_num_t;            // buffer page index
    typedef logic [7:0]  page_addr_t;           // word address inside a page
    typedef logic [1:0]  sensor_t;              // sensor index
    typedef logic [1:0]  sub_chn_t;             // histogram sub-channel
    typedef logic [1:0]  color_t;               // colour burst index
    typedef logic [3:0]  hist_chn_t;            // {sensor, sub_chn}, start page table index
    typedef logic [19:0] start_page_t;          // 4KB page number
    typedef logic [5:0]  axi_id_t;              // {hist_chn, colour}
    typedef logic [4:0]  cmd_addr_t;            // config register address
    typedef logic [3:0]  axi_len_t;
    typedef logic [3:0]  axi_cache_t;

    // mode register layout
    localparam int MODE_WIDTH     = 8;
    localparam int MODE_EN        = 0;
    localparam int MODE_NRESET    = 1;          // low holds the whole path cleared
    localparam int MODE_CONFIRM   = 2;          // wait for all responses before next page
    localparam int MODE_CACHE_LSB = 4;          // awcache in bits 7:4

    localparam cmd_addr_t CMD_MODE_ADDR = 5'd16; // 0..15 are the start page table

    localparam axi_len_t   AXI_LEN_16     = 4'd15;
    localparam logic [1:0] AXI_SIZE_4B    = 2'd2;
    localparam logic [1:0] AXI_BURST_INCR = 2'd1;

    localparam int BURSTS_PER_PAGE = 16;        // 256 words as 16-beat bursts

endpackage

// ==== verilog/hist_config.sv ====
`timescale 1ns/100ps
// configuration registers of the histogram transfer
// mode register and 16-entry start page table, loaded through the command port
module hist_config (
    input  logic                  aclk,
    input  logic                  mclk,
    input  logic                  cmd_we,
    input  hist_pkg::cmd_addr_t   cmd_addr,
    input  hist_pkg::hist_word_t  cmd_data,
    input  hist_pkg::hist_chn_t   tbl_idx,     // lookup from the page sequencer
    output logic                  en,
    output logic                  confirm,
    output hist_pkg::axi_cache_t  awcache,
    output hist_pkg::start_page_t start_page
);
    import hist_pkg::*;

    logic [MODE_WIDTH-1:0] mode;
    start_page_t           page_tbl [16];    // start page per {sensor, sub_chn}

    always_ff @(posedge aclk or posedge mclk) begin
        if (mclk)
            mode <= '0;                        // disabled after reset
        else if (cmd_we && cmd_addr == CMD_MODE_ADDR)
            mode <= cmd_data[MODE_WIDTH-1:0];
    end

    always_ff @(posedge aclk) begin
        if (cmd_we && !cmd_addr[4])
            page_tbl[cmd_addr[3:0]] <= cmd_data[$bits(start_page_t)-1:0];
    end

    assign en         = mode[MODE_EN] & mode[MODE_NRESET];
    assign confirm    = mode[MODE_CONFIRM];
    assign awcache    = mode[MODE_CACHE_LSB +: $bits(axi_cache_t)];
    assign start_page = page_tbl[tbl_idx];   // combinational lookup

endmodule

// ==== hist_buffer/hist_arbiter.sv ====
`timescale 1ns/100ps
// sensor arbitration and the write side of the page buffer
// locks on to the lowest requesting sensor for its four colour bursts,
// grants each burst when a page is free and streams the words into that page
module hist_arbiter #(
    parameter int NUM_FRAME_BITS = hist_pkg::NUM_FRAME_BITS_DEF
) (
    input  logic                      aclk,
    input  logic                      mclk,
    input  logic                      en,
    input  logic [NUM_FRAME_BITS-1:0] frame0, frame1, frame2, frame3,
    input  logic                      hist_request0, hist_request1, hist_request2, hist_request3,
    input  hist_pkg::sub_chn_t        hist_chn0, hist_chn1, hist_chn2, hist_chn3,
    input  logic                      hist_dvalid0, hist_dvalid1, hist_dvalid2, hist_dvalid3,
    input  hist_pkg::hist_word_t      hist_data0, hist_data1, hist_data2, hist_data3,
    output logic                      hist_grant0, hist_grant1, hist_grant2, hist_grant3,
    input  logic                      buf_full,
    output logic                      wr_en,
    output hist_pkg::page_num_t       wr_page,
    output hist_pkg::page_addr_t      wr_addr,
    output hist_pkg::hist_word_t      wr_data,
    output logic                      attr_we,
    output logic [NUM_FRAME_BITS+5:0] attr_data,   // {sensor, sub_chn, frame, colour}
    output logic                      page_written
);
    import hist_pkg::*;

    typedef enum logic [1:0] {IDLE, WAIT_GRANT, RECV} arb_state_t;

    arb_state_t                state;
    sensor_t                   sel;           // locked sensor
    sensor_t                   pri_sel;       // lowest index requester
    color_t                    color;         // colour burst in progress
    logic [3:0]                req_v;
    logic [3:0]                dv_v;
    logic [3:0]                grant_v;
    logic [NUM_FRAME_BITS-1:0] frame_a [4];
    sub_chn_t                  chn_a [4];
    hist_word_t                data_a [4];
    logic                      dv;
    logic                      dv_r;
    logic                      burst_done;

    assign req_v   = {hist_request3, hist_request2, hist_request1, hist_request0};
    assign dv_v    = {hist_dvalid3, hist_dvalid2, hist_dvalid1, hist_dvalid0};
    assign frame_a = '{frame0, frame1, frame2, frame3};
    assign chn_a   = '{hist_chn0, hist_chn1, hist_chn2, hist_chn3};
    assign data_a  = '{hist_data0, hist_data1, hist_data2, hist_data3};
    assign {hist_grant3, hist_grant2, hist_grant1, hist_grant0} = grant_v;

    assign pri_sel    = req_v[0] ? 2'd0 : req_v[1] ? 2'd1 : req_v[2] ? 2'd2 : 2'd3;
    assign dv         = dv_v[sel];
    assign burst_done = (state == RECV) && dv_r && !dv;      // falling edge of dvalid

    assign wr_en        = dv_r;                              // one cycle after dvalid
    assign page_written = burst_done;
    assign attr_we      = (state == WAIT_GRANT) && dv && !dv_r;
    assign attr_data    = {sel, chn_a[sel], frame_a[sel], color};

    always_ff @(posedge aclk) wr_data <= data_a[sel];

    always_ff @(posedge aclk or posedge mclk) begin
        if (mclk) begin
            {state, sel, color, dv_r, grant_v, wr_page, wr_addr} <= '0;
        end else if (!en) begin
            {state, sel, color, dv_r, grant_v, wr_page, wr_addr} <= '0;
        end else begin
            dv_r    <= dv;
            wr_addr <= dv_r ? wr_addr + 1'b1 : '0;
            // grant only between bursts, while the request holds and a page is free
            grant_v <= (state == WAIT_GRANT && req_v[sel] && !buf_full && !dv) ?
                       4'b0001 << sel : 4'b0000;
            case (state)
                IDLE: if (|req_v) begin
                    sel   <= pri_sel;
                    state <= WAIT_GRANT;
                end
                WAIT_GRANT: if (dv) state <= RECV;
                RECV: if (burst_done) begin
                    wr_page <= wr_page + 1'b1;
                    color   <= color + 1'b1;
                    state   <= (color == 2'd3) ? IDLE : WAIT_GRANT;  // four colours per histogram
                end
                default: state <= IDLE;
            endcase
        end
    end

    // a sensor starts a burst only after it has seen its grant
    for (genvar i = 0; i < 4; i++) begin : g_dv_chk
        a_dv_granted: assert property (@(posedge aclk) disable iff (mclk || !en)
            $rose(dv_v[i]) |-> $past(grant_v[i]));
    end

endmodule

// ==== hist_buffer/hist_page_buf.sv ====
`timescale 1ns/100ps
// four-page histogram buffer between the sensor side and the AXI side
// 1024x32 RAM with two-stage read, page attributes and occupancy count
module hist_page_buf #(
    parameter int NUM_FRAME_BITS = hist_pkg::NUM_FRAME_BITS_DEF
) (
    input  logic                      aclk,
    input  logic                      mclk,
    input  logic                      en,
    input  logic                      wr_en,
    input  hist_pkg::page_num_t       wr_page,
    input  hist_pkg::page_addr_t      wr_addr,
    input  hist_pkg::hist_word_t      wr_data,
    input  logic                      attr_we,
    input  logic [NUM_FRAME_BITS+5:0] attr_data,
    input  logic                      page_written,
    input  logic                      rd_en,
    input  hist_pkg::page_addr_t      rd_addr,
    input  logic                      page_sent,
    output hist_pkg::hist_word_t      rd_data,
    output logic [NUM_FRAME_BITS+5:0] attr_rd,     // attribute of the oldest page
    output logic                      buf_full,
    output logic                      buf_empty
);
    import hist_pkg::*;

    hist_word_t                ram [1024];
    hist_word_t                ram_q;            // first read stage
    logic [NUM_FRAME_BITS+5:0] attr_mem [4];
    page_num_t                 rd_page;          // oldest occupied page
    logic [2:0]                pages;            // occupied pages, 0..4
    logic                      rd_en_r;

    always_ff @(posedge aclk) begin
        if (wr_en) ram[{wr_page, wr_addr}] <= wr_data;
        if (rd_en) ram_q <= ram[{rd_page, rd_addr}];
        if (rd_en_r) rd_data <= ram_q;           // output register, 2 cycles after rd_en
        if (attr_we) attr_mem[wr_page] <= attr_data;
    end

    always_ff @(posedge aclk or posedge mclk) begin
        if (mclk) begin
            {rd_page, pages, rd_en_r} <= '0;
        end else if (!en) begin
            {rd_page, pages, rd_en_r} <= '0;
        end else begin
            rd_en_r <= rd_en;
            if (page_sent) rd_page <= rd_page + 1'b1;
            if (page_written && !page_sent)
                pages <= pages + 1'b1;
            else if (!page_written && page_sent)
                pages <= pages - 1'b1;
        end
    end

    assign attr_rd   = attr_mem[rd_page];
    assign buf_full  = pages[2];
    assign buf_empty = (pages == 3'd0);

    // the arbiter and the page sequencer must respect the occupancy
    a_occupancy: assert property (@(posedge aclk) disable iff (mclk || !en)
        !(page_written && buf_full) && !(page_sent && buf_empty));

endmodule

// ==== hist_saxi/hist_block_ctrl.sv ====
`timescale 1ns/100ps
// page sequencer on the AXI side
// takes the oldest buffered page, forms its system memory address from the
// start page table, frame and colour, and issues its 16 AW bursts
module hist_block_ctrl #(
    parameter int NUM_FRAME_BITS = hist_pkg::NUM_FRAME_BITS_DEF
) (
    input  logic                      aclk,
    input  logic                      mclk,
    input  logic                      en,
    input  logic                      buf_empty,
    input  logic [NUM_FRAME_BITS+5:0] attr_rd,
    input  hist_pkg::start_page_t     start_page,
    input  logic                      block_done,
    output hist_pkg::hist_chn_t       tbl_idx,
    output logic                      block_start,
    output logic                      page_sent,
    output hist_pkg::axi_id_t         axi_id,
    output hist_pkg::axi_addr_t       awaddr,
    output logic                      awvalid,
    input  logic                      awready,
    output hist_pkg::axi_len_t        awlen,
    output logic [1:0]                awsize,
    output logic [1:0]                awburst,
    output hist_pkg::axi_cache_t      awcache,
    output hist_pkg::axi_id_t         awid,
    input  hist_pkg::axi_cache_t      awcache_mode
);
    import hist_pkg::*;

    typedef enum logic [2:0] {IDLE, LOAD, ADDR, SEND, DRAIN} block_state_t;

    block_state_t              state;
    logic [NUM_FRAME_BITS+5:0] attr_r;           // attribute of the page in progress
    start_page_t               page_r;
    logic [3:0]                aw_cnt;           // AW bursts accepted for this page
    logic [NUM_FRAME_BITS-1:0] frame;
    color_t                    color;

    assign tbl_idx = attr_r[NUM_FRAME_BITS+2 +: $bits(hist_chn_t)];
    assign frame   = attr_r[2 +: NUM_FRAME_BITS];
    assign color   = attr_r[1:0];
    assign axi_id  = {tbl_idx, color};
    assign awid    = axi_id;
    assign awlen   = AXI_LEN_16;
    assign awsize  = AXI_SIZE_4B;
    assign awburst = AXI_BURST_INCR;

    assign awvalid     = (state == SEND);
    assign block_start = (state == ADDR);        // starts page readout
    assign page_sent   = (state == DRAIN) && block_done;

    always_ff @(posedge aclk) begin
        case (state)
            IDLE: begin
                attr_r  <= attr_rd;
                awcache <= awcache_mode;         // cache mode fixed for the whole page
            end
            LOAD: page_r <= start_page;
            ADDR: awaddr <= {page_r + start_page_t'(frame), color, 10'b0};
            SEND: if (awready) awaddr <= awaddr + 32'd64;   // next 16-word burst
            default: ;
        endcase
    end

    always_ff @(posedge aclk or posedge mclk) begin
        if (mclk) begin
            {state, aw_cnt} <= '0;
        end else if (!en) begin
            {state, aw_cnt} <= '0;
        end else begin
            case (state)
                IDLE:  if (!buf_empty) state <= LOAD;
                LOAD:  state <= ADDR;
                ADDR:  state <= SEND;
                SEND:  if (awready) begin
                    aw_cnt <= aw_cnt + 1'b1;     // wraps to 0 after the last burst
                    if (aw_cnt == 4'(BURSTS_PER_PAGE - 1)) state <= DRAIN;
                end
                DRAIN: if (block_done) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// ==== hist_saxi/hist_wdata.sv ====
`timescale 1ns/100ps
// page readout and the AXI W channel
// reads the page into a 4-deep FIFO that hides the RAM latency, sends it as
// 16-beat bursts and reports block_done when the page has gone out
module hist_wdata (
    input  logic                 aclk,
    input  logic                 mclk,
    input  logic                 en,
    input  logic                 confirm,
    input  logic                 block_start,
    input  hist_pkg::hist_word_t rd_data,
    output logic                 rd_en,
    output hist_pkg::page_addr_t rd_addr,
    output hist_pkg::hist_word_t wdata,
    output logic                 wvalid,
    input  logic                 wready,
    output logic                 wlast,
    output logic [3:0]           wstrb,
    input  logic                 bvalid,
    output logic                 block_done
);
    import hist_pkg::*;

    hist_word_t fifo [4];
    logic [1:0] wp;
    logic [1:0] rp;
    logic [2:0] cnt;            // fifo occupancy
    logic [1:0] re_d;           // read pipeline, data lands with re_d[1]
    logic       running;        // page readout in progress
    logic [3:0] beat;           // beat within the burst
    logic [4:0] bursts_left;    // bursts of this page not yet sent
    logic [5:0] pending;        // bursts sent and not yet answered
    logic       fire;

    // stop at half full, the reads in flight fill the rest
    assign rd_en      = en && running && (cnt < 3'd2);
    assign wvalid     = (cnt != 3'd0);
    assign fire       = wvalid && wready;
    assign wdata      = fifo[rp];
    assign wlast      = &beat;
    assign wstrb      = 4'hf;
    assign block_done = (bursts_left == 5'd0) && (!confirm || pending == 6'd0);

    always_ff @(posedge aclk) begin
        if (re_d[1]) fifo[wp] <= rd_data;
    end

    always_ff @(posedge aclk or posedge mclk) begin
        if (mclk) begin
            {re_d, running, rd_addr, wp, rp, cnt, beat, bursts_left, pending} <= '0;
        end else if (!en) begin
            {re_d, running, rd_addr, wp, rp, cnt, beat, bursts_left, pending} <= '0;
        end else begin
            re_d <= {re_d[0], rd_en};
            if (block_start)
                running <= 1'b1;
            else if (rd_en && &rd_addr)
                running <= 1'b0;                 // last word of the page requested
            if (block_start)
                rd_addr <= '0;
            else if (rd_en)
                rd_addr <= rd_addr + 1'b1;
            if (re_d[1]) wp <= wp + 1'b1;
            if (fire) begin
                rp   <= rp + 1'b1;
                beat <= beat + 1'b1;
            end
            cnt <= cnt + 3'(re_d[1]) - 3'(fire);
            if (block_start)
                bursts_left <= 5'(BURSTS_PER_PAGE);
            else if (fire && wlast)
                bursts_left <= bursts_left - 1'b1;
            pending <= pending + 6'(fire && wlast) - 6'(bvalid);   // bready is always high
        end
    end

    // reads in flight never land in a full fifo
    a_fifo_ovf: assert property (@(posedge aclk) disable iff (mclk || !en)
        re_d[1] && !fire |-> cnt < 3'd4);

endmodule

// ==== verilog/hist_saxi_top.sv ====
`timescale 1ns/100ps
// histogram transfer from four sensors to system memory over AXI write channels
// configure through the command port, then enable with the mode register
module hist_saxi_top #(
    parameter int NUM_FRAME_BITS = hist_pkg::NUM_FRAME_BITS_DEF
) (
    input  logic                      aclk,
    input  logic                      mclk,
    input  logic                      cmd_we,
    input  hist_pkg::cmd_addr_t       cmd_addr,
    input  hist_pkg::hist_word_t      cmd_data,
    input  logic [NUM_FRAME_BITS-1:0] frame0, frame1, frame2, frame3,
    input  logic                      hist_request0, hist_request1, hist_request2, hist_request3,
    input  hist_pkg::sub_chn_t        hist_chn0, hist_chn1, hist_chn2, hist_chn3,
    input  logic                      hist_dvalid0, hist_dvalid1, hist_dvalid2, hist_dvalid3,
    input  hist_pkg::hist_word_t      hist_data0, hist_data1, hist_data2, hist_data3,
    output logic                      hist_grant0, hist_grant1, hist_grant2, hist_grant3,
    output hist_pkg::axi_addr_t       awaddr,
    output logic                      awvalid,
    input  logic                      awready,
    output hist_pkg::axi_id_t         awid,
    output hist_pkg::axi_len_t        awlen,
    output logic [1:0]                awsize,
    output logic [1:0]                awburst,
    output hist_pkg::axi_cache_t      awcache,
    output hist_pkg::hist_word_t      wdata,
    output logic                      wvalid,
    input  logic                      wready,
    output hist_pkg::axi_id_t         wid,
    output logic                      wlast,
    output logic [3:0]                wstrb,
    input  logic                      bvalid,
    output logic                      bready
);
    import hist_pkg::*;

    logic                      en, confirm;
    hist_chn_t                 tbl_idx;
    axi_cache_t                awcache_mode;
    start_page_t               start_page;
    logic                      wr_en, attr_we, page_written, buf_full, buf_empty;
    page_num_t                 wr_page;
    page_addr_t                wr_addr, rd_addr;
    hist_word_t                wr_data, rd_data;
    logic [NUM_FRAME_BITS+5:0] attr_data, attr_rd;
    logic                      rd_en, page_sent, block_start, block_done;
    axi_id_t                   axi_id;

    assign wid    = axi_id;               // W bursts follow AW order
    assign bready = 1'b1;

    hist_config config0 (.awcache(awcache_mode), .*);

    hist_arbiter #(.NUM_FRAME_BITS(NUM_FRAME_BITS)) arbiter0 (.*);

    hist_page_buf #(.NUM_FRAME_BITS(NUM_FRAME_BITS)) page_buf0 (.*);

    hist_block_ctrl #(.NUM_FRAME_BITS(NUM_FRAME_BITS)) block_ctrl0 (.*);

    hist_wdata wdata0 (.*);

endmodule

// ==== dv/tb_hist_saxi.sv ====
`timescale 1ns/100ps
// directed testbench of the histogram to AXI write path
// drives the sensor and command ports, models an AXI slave memory with stalls,
// and checks every stored word against the address rule of the design
module tb_hist_saxi;
    import hist_pkg::*;

    localparam int FRAME_BITS  = 4;
    localparam int TOTAL_HIST  = 6;                              // histograms over all tests
    localparam int WATCHDOG_NS = TOTAL_HIST * 1024 * 4 * 4 * 4;  // words x cycles x margin x period

    logic        aclk, mclk, cmd_we;
    cmd_addr_t   cmd_addr;
    hist_word_t  cmd_data;
    logic [FRAME_BITS-1:0] frame_v [4];
    sub_chn_t    chn_v [4];
    hist_word_t  data_v [4];
    logic [3:0]  req, dvalid, grant;
    axi_addr_t   awaddr;
    logic        awvalid, awready, wvalid, wready, wlast, bvalid, bready;
    axi_id_t     awid, wid;
    axi_len_t    awlen;
    logic [1:0]  awsize, awburst;
    axi_cache_t  awcache, cur_cache;                        // cur_cache is the programmed value
    hist_word_t  wdata;
    logic [3:0]  wstrb;

    integer      seed = 32'hf93a8f8b;
    string       test_name;
    logic        stalls;                                    // random ready and response delays
    start_page_t start_tbl [16];
    hist_word_t  mem [axi_addr_t];                          // slave memory
    axi_id_t     mem_id [axi_addr_t];                       // id of the burst that wrote the word
    axi_addr_t   aw_addr_q [$];
    axi_id_t     aw_id_q [$];
    hist_word_t  w_data_q [$];
    axi_id_t     w_id_q [$];
    sensor_t     burst_order [$];                           // sensor of each finished colour burst
    axi_addr_t   last_aw;
    int          aw_total = 0;
    int          w_total = 0;
    int          resolved = 0;                              // bursts with address and data matched
    int          b_sent = 0;

    hist_saxi_top #(.NUM_FRAME_BITS(FRAME_BITS)) dut0 (
        .frame0(frame_v[0]), .frame1(frame_v[1]), .frame2(frame_v[2]), .frame3(frame_v[3]),
        .hist_request0(req[0]), .hist_request1(req[1]),
        .hist_request2(req[2]), .hist_request3(req[3]),
        .hist_chn0(chn_v[0]), .hist_chn1(chn_v[1]), .hist_chn2(chn_v[2]), .hist_chn3(chn_v[3]),
        .hist_dvalid0(dvalid[0]), .hist_dvalid1(dvalid[1]),
        .hist_dvalid2(dvalid[2]), .hist_dvalid3(dvalid[3]),
        .hist_data0(data_v[0]), .hist_data1(data_v[1]),
        .hist_data2(data_v[2]), .hist_data3(data_v[3]),
        .hist_grant0(grant[0]), .hist_grant1(grant[1]),
        .hist_grant2(grant[2]), .hist_grant3(grant[3]),
        .*
    );

    initial aclk = 1'b0;
    always #2 aclk = ~aclk;                                 // 4 ns period

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_addr(input string what, input axi_addr_t exp, input axi_addr_t act);
        if (exp !== act)
            stop_on_error($sformatf("ERR %s %s expected %h actual %h", test_name, what, exp, act));
    endtask

    task automatic check_word(input string what, input hist_word_t exp, input hist_word_t act);
        if (exp !== act)
            stop_on_error($sformatf("ERR %s %s expected %h actual %h", test_name, what, exp, act));
    endtask

    task automatic check_id(input string what, input axi_id_t exp, input axi_id_t act);
        if (exp !== act)
            stop_on_error($sformatf("ERR %s %s expected %h actual %h", test_name, what, exp, act));
    endtask

    task automatic check_field(input string what, input logic [3:0] exp, input logic [3:0] act);
        if (exp !== act)
            stop_on_error($sformatf("ERR %s %s expected %h actual %h", test_name, what, exp, act));
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (exp !== act)
            stop_on_error($sformatf("ERR %s %s expected %b actual %b", test_name, what, exp, act));
    endtask

    task automatic check_sensor(input string what, input sensor_t exp, input sensor_t act);
        if (exp !== act)
            stop_on_error($sformatf("ERR %s %s expected %0d actual %0d", test_name, what, exp, act));
    endtask

    // data word tagged with sensor, colour and word index
    function automatic hist_word_t word_of(input sensor_t s, input int c, input int i);
        return {8'hc3, 6'd0, s, 6'd0, 2'(c), 8'(i)};
    endfunction

    // (start page + frame) x 4KB + colour x 1KB + index x 4
    function automatic axi_addr_t hist_addr(input sensor_t s, input sub_chn_t sub,
                                            input logic [FRAME_BITS-1:0] frm,
                                            input int c, input int i);
        axi_addr_t page;
        page = axi_addr_t'(start_tbl[{s, sub}]) + axi_addr_t'(frm);
        return page * 4096 + axi_addr_t'(c * 1024 + i * 4);
    endfunction

    task automatic receive_aw();
        check_field("awlen", 4'd15, awlen);
        check_field("awsize", 4'd2, 4'(awsize));
        check_field("awburst", 4'd1, 4'(awburst));
        check_field("awcache", cur_cache, awcache);
        check_addr("awaddr alignment", {awaddr[31:6], 6'd0}, awaddr);
        if (aw_total % 16 != 0)
            check_addr("awaddr step", last_aw + 32'd64, awaddr);   // bursts of a page in order
        last_aw = awaddr;
        aw_total++;
        aw_addr_q.push_back(awaddr);
        aw_id_q.push_back(awid);
    endtask

    task automatic receive_w();
        check_field("wstrb", 4'hf, wstrb);
        check_flag("wlast", (w_total % 16) == 15, wlast);
        w_total++;
        w_data_q.push_back(wdata);
        w_id_q.push_back(wid);
    endtask

    task automatic store_word(input axi_addr_t a, input hist_word_t d, input axi_id_t id);
        if (mem.exists(a))
            stop_on_error($sformatf("%s: address %h written more than once", test_name, a));
        mem[a]    = d;
        mem_id[a] = id;
    endtask

    // pair each accepted address with its 16 data beats
    task automatic resolve_bursts();
        axi_addr_t a;
        axi_id_t   id;
        while (aw_addr_q.size() > 0 && w_data_q.size() >= 16) begin
            a  = aw_addr_q.pop_front();
            id = aw_id_q.pop_front();
            for (int k = 0; k < 16; k++) begin
                check_id("wid", id, w_id_q.pop_front());
                store_word(a + axi_addr_t'(4 * k), w_data_q.pop_front(), id);
            end
            resolved++;
        end
    endtask

    // AXI slave, takes transfers at the edge and sets ready/response just after it
    always @(posedge aclk) begin
        if (awvalid && awready) receive_aw();
        if (wvalid && wready) receive_w();
        if (bvalid) begin
            check_flag("bready", 1'b1, bready);             // every response taken at once
            b_sent++;
        end
        resolve_bursts();
        #1;
        awready = !stalls || (($random(seed) & 3) != 0);
        wready  = !stalls || (($random(seed) & 3) > 1);
        bvalid  = (resolved > b_sent) && (!stalls || (($random(seed) & 3) == 0));
    end

    task automatic write_cfg(input cmd_addr_t a, input hist_word_t d);
        cmd_we   = 1'b1;
        cmd_addr = a;
        cmd_data = d;
        @(posedge aclk);
        #1;
        cmd_we   = 1'b0;
    endtask

    task automatic program_table();
        for (int i = 0; i < 16; i++) begin
            start_tbl[i] = 20'h3a000 + 20'(i * 37);          // 37 pages apart, frames never overlap
            write_cfg(cmd_addr_t'(i), hist_word_t'(start_tbl[i]));
        end
    endtask

    task automatic set_mode(input logic confirm, input axi_cache_t cache);
        cur_cache = cache;
        write_cfg(CMD_MODE_ADDR, {24'd0, cache, 1'b0, confirm, 2'b11});   // enabled, out of reset
    endtask

    // one sensor, four granted colour bursts of 256 words
    task automatic send_histogram(input sensor_t s, input sub_chn_t sub,
                                  input logic [FRAME_BITS-1:0] frm);
        frame_v[s] = frm;
        chn_v[s]   = sub;
        req[s]     = 1'b1;                                  // held for the whole histogram
        for (int c = 0; c < 4; c++) begin
            do begin
                @(posedge aclk);
                #1;
            end while (!grant[s]);
            @(posedge aclk);                                // grant seen for a full cycle
            #1;
            for (int i = 0; i < 256; i++) begin
                dvalid[s] = 1'b1;
                data_v[s] = word_of(s, c, i);
                @(posedge aclk);
                #1;
            end
            dvalid[s] = 1'b0;                               // falling edge commits the page
            if (c == 3) req[s] = 1'b0;
            burst_order.push_back(s);
        end
    endtask

    task automatic clear_memory();
        mem.delete();
        mem_id.delete();
        burst_order.delete();
    endtask

    // all words stored and all responses given
    task automatic wait_drained(input int n);
        while (mem.num() < n || resolved != b_sent || aw_addr_q.size() != 0 ||
               w_data_q.size() != 0) begin
            @(posedge aclk);
            #1;
        end
        if (mem.num() != n)
            stop_on_error($sformatf("%s: %0d words written, %0d wanted", test_name, mem.num(), n));
    endtask

    task automatic verify_histogram(input sensor_t s, input sub_chn_t sub,
                                    input logic [FRAME_BITS-1:0] frm);
        axi_addr_t a;
        for (int c = 0; c < 4; c++) begin
            for (int i = 0; i < 256; i++) begin
                a = hist_addr(s, sub, frm, c, i);
                if (!mem.exists(a))
                    stop_on_error($sformatf("%s: nothing written at address %h", test_name, a));
                check_word("data", word_of(s, c, i), mem[a]);
                check_id("awid", {s, sub, 2'(c)}, mem_id[a]);
            end
        end
    endtask

    task automatic reset_and_disable();
        test_name = "reset_and_disable";
        check_flag("awvalid", 1'b0, awvalid);
        check_flag("wvalid", 1'b0, wvalid);
        check_field("grants", 4'h0, grant);
        write_cfg(CMD_MODE_ADDR, 32'h02);                   // out of reset but not enabled
        req[2] = 1'b1;
        repeat (100) begin
            @(posedge aclk);
            #1;
            check_flag("grant while disabled", 1'b0, grant[2]);
        end
        req[2] = 1'b0;
    endtask

    task automatic single_histogram();
        test_name = "single_histogram";
        set_mode(1'b0, 4'h3);
        clear_memory();
        send_histogram(2'd1, 2'd2, 4'd5);
        wait_drained(1024);
        verify_histogram(2'd1, 2'd2, 4'd5);
    endtask

    task automatic axi_fields();
        test_name = "axi_fields";                           // fields are checked per transfer
        set_mode(1'b0, 4'ha);
        clear_memory();
        send_histogram(2'd2, 2'd1, 4'd9);
        wait_drained(1024);
        verify_histogram(2'd2, 2'd1, 4'd9);
    endtask

    task automatic priority_order();
        test_name = "priority_order";
        set_mode(1'b0, 4'h6);
        clear_memory();
        fork
            send_histogram(2'd0, 2'd3, 4'd2);
            send_histogram(2'd3, 2'd0, 4'd12);
        join
        wait_drained(2048);
        for (int k = 0; k < 8; k++)
            check_sensor("burst owner", (k < 4) ? 2'd0 : 2'd3, burst_order[k]);
        verify_histogram(2'd0, 2'd3, 4'd2);
        verify_histogram(2'd3, 2'd0, 4'd12);
    endtask

    task automatic backpressure_confirm();
        test_name = "backpressure_confirm";
        set_mode(1'b1, 4'h5);
        stalls = 1'b1;
        clear_memory();
        fork
            send_histogram(2'd1, 2'd3, 4'd7);
            send_histogram(2'd2, 2'd0, 4'd3);
        join
        wait_drained(2048);
        verify_histogram(2'd1, 2'd3, 4'd7);
        verify_histogram(2'd2, 2'd0, 4'd3);
        stalls = 1'b0;
    endtask

    initial begin
        #(WATCHDOG_NS);
        stop_on_error("watchdog timeout, the histogram transfers did not complete in time");
    end

    initial begin
        mclk      = 1'b1;
        cmd_we    = 1'b0;
        cmd_addr  = '0;
        cmd_data  = '0;
        req       = '0;
        dvalid    = '0;
        awready   = 1'b0;
        wready    = 1'b0;
        bvalid    = 1'b0;
        stalls    = 1'b0;
        cur_cache = '0;
        for (int s = 0; s < 4; s++) begin
            frame_v[s] = '0;
            chn_v[s]   = '0;
            data_v[s]  = '0;
        end
        repeat (2) @(posedge aclk);
        #1;
        mclk = 1'b0;
        reset_and_disable();
        program_table();
        single_histogram();
        axi_fields();
        priority_order();
        backpressure_confirm();
        $display("Finished with no errors");
        $finish;
    end

endmodule

// ==== src.f ====
common/hist_pkg.sv
verilog/hist_config.sv
hist_buffer/hist_arbiter.sv
hist_buffer/hist_page_buf.sv
hist_saxi/hist_block_ctrl.sv
hist_saxi/hist_wdata.sv
verilog/hist_saxi_top.sv
dv/tb_hist_saxi.sv

// ==== Makefile ====
# Verilator simulation of the histogram AXI write path

SIM  := obj_dir/Vtb_hist_saxi
SRCS := $(shell cat src.f)

.PHONY: all run clean

all: run

$(SIM): src.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_hist_saxi -f src.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log
